//--- rtl/alu_execute.sv
`default_nettype none

module alu_execute (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue_fire,
    input  rv_issue_pkg::alu_op_e         op,
    input  logic                          rs1_use_reg,
    input  logic                          rs2_use_reg,
    input  logic [rv_issue_pkg::XLEN-1:0] pc_operand,
    input  logic [rv_issue_pkg::XLEN-1:0] imm_operand,
    input  rv_issue_pkg::reg_addr_t       dest_rd,
    input  logic                          writes_rd,
    input  logic [rv_issue_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_issue_pkg::XLEN-1:0] rs2_data,
    output logic                          exec_valid,
    output rv_issue_pkg::reg_addr_t       exec_rd,
    output logic [rv_issue_pkg::XLEN-1:0] exec_data
);
    import rv_issue_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic            subtract;
    logic            signed_cmp;
    logic [XLEN:0]   add_a;
    logic [XLEN:0]   add_b;
    logic [XLEN:0]   add_sum;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_result;
    logic            capture;

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    assign src_a = rs1_use_reg ? rs1_data : pc_operand;
    assign src_b = rs2_use_reg ? rs2_data : imm_operand;

    // One adder for add, subtract and both compares
    assign subtract   = op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign signed_cmp = (op != ALU_SLTU);

    // Extra top bit makes the borrow the less-than flag
    assign add_a   = {signed_cmp & src_a[XLEN-1], src_a};
    assign add_b   = {signed_cmp & src_b[XLEN-1], src_b};
    assign add_sum = add_a + (subtract ? ~add_b : add_b) + {{XLEN{1'b0}}, subtract};

    assign shamt = src_b[4:0];

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB:  alu_result = add_sum[XLEN-1:0];
            ALU_SLT,
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, add_sum[XLEN]};
            ALU_XOR:  alu_result = src_a ^ src_b;
            ALU_OR:   alu_result = src_a | src_b;
            ALU_AND:  alu_result = src_a & src_b;
            ALU_SLL:  alu_result = src_a << shamt;
            ALU_SRL:  alu_result = src_a >> shamt;
            ALU_SRA:  alu_result = XLEN'($signed(src_a) >>> shamt);
            default:  alu_result = add_sum[XLEN-1:0];
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Execute stage register
    // Non-writing instructions leave no result behind
    assign capture = issue_fire & writes_rd;

    always_ff @(posedge clk) begin
        if (rst)
            exec_valid <= 1'b0;
        else
            exec_valid <= capture;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            exec_rd   <= dest_rd;
            exec_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
`default_nettype none

module instr_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [rv_issue_pkg::XLEN-1:0] instr_pc,
    input  rv_issue_pkg::instr_word_u     instr_word,
    input  logic                          hold,
    input  logic                          exec_valid,
    input  rv_issue_pkg::reg_addr_t       exec_rd,
    output logic                          decode_advance,
    output logic                          issue_fire,
    output rv_issue_pkg::alu_op_e         op,
    output logic                          rs1_use_reg,
    output logic                          rs2_use_reg,
    output logic [rv_issue_pkg::XLEN-1:0] pc_operand,
    output logic [rv_issue_pkg::XLEN-1:0] imm_operand,
    output rv_issue_pkg::reg_addr_t       dest_rd,
    output rv_issue_pkg::reg_addr_t       rs1_addr,
    output rv_issue_pkg::reg_addr_t       rs2_addr,
    output logic                          writes_rd
);
    import rv_issue_pkg::*;

    logic            is_op;
    logic            is_op_imm;
    logic            is_lui;
    logic            is_auipc;
    logic            is_shift_imm;
    logic [2:0]      fn3;
    logic            alt_fn;
    alu_op_e         dec_op;
    logic [XLEN-1:0] dec_imm;
    logic            stage_valid;
    logic            accept_en;
    logic            rs1_conflict;
    logic            rs2_conflict;

    //////////////////////////////////////////////////////////////////////
    // Field decode
    assign is_op     = (instr_word.r.opcode == OPC_OP);
    assign is_op_imm = (instr_word.r.opcode == OPC_OP_IMM);
    assign is_lui    = (instr_word.u.opcode == OPC_LUI);
    assign is_auipc  = (instr_word.u.opcode == OPC_AUIPC);
    assign fn3       = instr_word.r.fn3;
    // Bit 30 selects SUB and SRA/SRAI
    assign alt_fn    = instr_word.r.fn7[5];

    assign is_shift_imm = is_op_imm && (fn3 inside {F3_SLL, F3_SR});

    always_comb begin
        dec_op = ALU_ADD;
        if (is_op || is_op_imm) begin
            case (fn3)
                F3_ADD_SUB: dec_op = (is_op && alt_fn) ? ALU_SUB : ALU_ADD;
                F3_SLL:     dec_op = ALU_SLL;
                F3_SLT:     dec_op = ALU_SLT;
                F3_SLTU:    dec_op = ALU_SLTU;
                F3_XOR:     dec_op = ALU_XOR;
                F3_SR:      dec_op = alt_fn ? ALU_SRA : ALU_SRL;
                F3_OR:      dec_op = ALU_OR;
                F3_AND:     dec_op = ALU_AND;
                default:    dec_op = ALU_ADD;
            endcase
        end
    end

    // Upper immediates ride the adder with a zero or PC first operand
    always_comb begin
        if (is_lui || is_auipc)
            dec_imm = {instr_word.u.imm20, 12'b0};
        else if (is_shift_imm)
            dec_imm = XLEN'(instr_word.r.rs2);
        else
            dec_imm = XLEN'(signed'(instr_word.i.imm12));
    end

    //////////////////////////////////////////////////////////////////////
    // Issue stage register
    assign decode_advance = accept_en & ~hold & (~stage_valid | issue_fire);

    always_ff @(posedge clk) begin
        if (rst)
            accept_en <= 1'b0;
        else
            accept_en <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            stage_valid <= 1'b0;
        else if (decode_advance)
            stage_valid <= instr_valid;
    end

    always_ff @(posedge clk) begin
        if (decode_advance && instr_valid) begin
            op          <= dec_op;
            rs1_use_reg <= is_op | is_op_imm;
            rs2_use_reg <= is_op;
            pc_operand  <= is_auipc ? instr_pc : '0;
            imm_operand <= dec_imm;
            dest_rd     <= instr_word.r.rd;
            rs1_addr    <= instr_word.r.rs1;
            rs2_addr    <= instr_word.r.rs2;
            writes_rd   <= is_op | is_op_imm | is_lui | is_auipc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand conflict against the instruction in execute
    // x0 is never a real dependence
    assign rs1_conflict = exec_valid && (exec_rd != '0) && rs1_use_reg && (exec_rd == rs1_addr);
    assign rs2_conflict = exec_valid && (exec_rd != '0) && rs2_use_reg && (exec_rd == rs2_addr);

    assign issue_fire = stage_valid & ~hold & ~rs1_conflict & ~rs2_conflict;

endmodule

`default_nettype wire

//--- rtl/issue_core_top.sv
`default_nettype none

module issue_core_top #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [rv_issue_pkg::XLEN-1:0] instr_pc,
    input  rv_issue_pkg::instr_word_u     instr_word,
    input  logic                          hold,
    output logic                          decode_advance,
    output logic                          result_valid,
    output rv_issue_pkg::reg_addr_t       result_rd,
    output logic [rv_issue_pkg::XLEN-1:0] result_data
);
    import rv_issue_pkg::*;

    logic            issue_fire;
    alu_op_e         op;
    logic            rs1_use_reg;
    logic            rs2_use_reg;
    logic [XLEN-1:0] pc_operand;
    logic [XLEN-1:0] imm_operand;
    reg_addr_t       dest_rd;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic            writes_rd;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    //////////////////////////////////////////////////////////////////////
    // Decode and issue
    instr_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_word     (instr_word),
        .hold           (hold),
        .exec_valid     (result_valid),
        .exec_rd        (result_rd),
        .decode_advance (decode_advance),
        .issue_fire     (issue_fire),
        .op             (op),
        .rs1_use_reg    (rs1_use_reg),
        .rs2_use_reg    (rs2_use_reg),
        .pc_operand     (pc_operand),
        .imm_operand    (imm_operand),
        .dest_rd        (dest_rd),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .writes_rd      (writes_rd)
    );

    // Execute results are the top outputs directly
    alu_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .issue_fire  (issue_fire),
        .op          (op),
        .rs1_use_reg (rs1_use_reg),
        .rs2_use_reg (rs2_use_reg),
        .pc_operand  (pc_operand),
        .imm_operand (imm_operand),
        .dest_rd     (dest_rd),
        .writes_rd   (writes_rd),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .exec_valid  (result_valid),
        .exec_rd     (result_rd),
        .exec_data   (result_data)
    );

    reg_result #(
        .REG_COUNT (REG_COUNT)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .exec_valid (result_valid),
        .exec_rd    (result_rd),
        .exec_data  (result_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

endmodule

`default_nettype wire

//--- rtl/reg_result.sv
`default_nettype none

module reg_result #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          exec_valid,
    input  rv_issue_pkg::reg_addr_t       exec_rd,
    input  logic [rv_issue_pkg::XLEN-1:0] exec_data,
    input  rv_issue_pkg::reg_addr_t       rs1_addr,
    input  rv_issue_pkg::reg_addr_t       rs2_addr,
    output logic [rv_issue_pkg::XLEN-1:0] rs1_data,
    output logic [rv_issue_pkg::XLEN-1:0] rs2_data
);
    import rv_issue_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];
    logic            wr_en;

    // x0 and indices past the file are not backed by storage
    function automatic logic backed(reg_addr_t addr);
        return (addr != '0) && (int'(addr) < REG_COUNT);
    endfunction

    assign wr_en = exec_valid & backed(exec_rd);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[exec_rd] <= exec_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Asynchronous read ports
    assign rs1_data = backed(rs1_addr) ? regs[rs1_addr] : '0;
    assign rs2_data = backed(rs2_addr) ? regs[rs2_addr] : '0;

endmodule

`default_nettype wire

//--- rtl/rv_issue_pkg.sv
`default_nettype none

package rv_issue_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // Function-3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction word, read as R, I or U format
    typedef union packed {
        struct packed {
            logic [6:0] fn7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] fn3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  fn3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [19:0] imm20;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u;
    } instr_word_u;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the issue core simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module issue_core_tb \
    --Mdir obj_dir \
    -o issue_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/issue_core_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
if grep -q "sim passed" sim.log; then
    exit 0
fi
echo "No result line found in sim.log"
exit 1

//--- tb/issue_core_properties.sv
`default_nettype none

module issue_core_properties (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire logic                    hold,
    input wire logic                    issue_fire,
    input wire logic                    decode_advance,
    input wire logic                    exec_valid,
    input wire rv_issue_pkg::reg_addr_t exec_rd,
    input wire logic                    rs1_use_reg,
    input wire logic                    rs2_use_reg,
    input wire rv_issue_pkg::reg_addr_t rs1_addr,
    input wire rv_issue_pkg::reg_addr_t rs2_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    logic conflict;

    // Source register waits on the result still in execute
    assign conflict = exec_valid && (exec_rd != 5'd0)
                      && ((rs1_use_reg && (exec_rd == rs1_addr))
                          || (rs2_use_reg && (exec_rd == rs2_addr)));

    no_fire_on_hold: assert property (@(posedge clk) disable iff (rst) hold |-> !issue_fire)
        else $error("issue_fire high while hold is high");

    no_fire_on_conflict: assert property (@(posedge clk) disable iff (rst)
        conflict |-> !issue_fire)
        else $error("issue_fire high during an operand conflict");

    no_advance_in_reset: assert property (@(posedge clk) rst |-> (decode_advance !== 1'b1))
        else $error("decode_advance high during reset");

endmodule

bind instr_decode issue_core_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .hold           (hold),
    .issue_fire     (issue_fire),
    .decode_advance (decode_advance),
    .exec_valid     (exec_valid),
    .exec_rd        (exec_rd),
    .rs1_use_reg    (rs1_use_reg),
    .rs2_use_reg    (rs2_use_reg),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr)
);

`default_nettype wire

//--- tb/issue_core_tb.sv
`default_nettype none

module issue_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_issue_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_TESTS      = 32;
    localparam int DRAIN_CYCLES = 20;

    typedef struct {
        string           name;
        instr_word_u     word;
        logic [XLEN-1:0] pc;
        int              holds;
        bit              has_result;
        reg_addr_t       rd;
        logic [XLEN-1:0] value;
    } test_entry_t;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    logic [XLEN-1:0] instr_pc;
    instr_word_u     instr_word;
    logic            hold;
    logic            decode_advance;
    logic            result_valid;
    reg_addr_t       result_rd;
    logic [XLEN-1:0] result_data;

    test_entry_t tbl [N_TESTS];
    int          n_entries;
    int          pending [$];
    int          expect_total;
    int          results_seen;
    int          rd_errors;
    int          data_errors;
    int          other_errors;
    int          drain;
    integer      seed;

    issue_core_top #(
        .REG_COUNT (32)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_word     (instr_word),
        .hold           (hold),
        .decode_advance (decode_advance),
        .result_valid   (result_valid),
        .result_rd      (result_rd),
        .result_data    (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding by RV32I format
    function automatic instr_word_u make_r(logic [6:0] fn7, reg_addr_t rs2, reg_addr_t rs1,
                                           logic [2:0] fn3, reg_addr_t rd, logic [6:0] opc);
        instr_word_u w;
        w.r.fn7    = fn7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.fn3    = fn3;
        w.r.rd     = rd;
        w.r.opcode = opc;
        return w;
    endfunction

    function automatic instr_word_u make_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] fn3,
                                           reg_addr_t rd, logic [6:0] opc);
        instr_word_u w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.fn3    = fn3;
        w.i.rd     = rd;
        w.i.opcode = opc;
        return w;
    endfunction

    function automatic instr_word_u make_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
        instr_word_u w;
        w.u.imm20  = imm;
        w.u.rd     = rd;
        w.u.opcode = opc;
        return w;
    endfunction

    task automatic add_test(string name, instr_word_u word, logic [XLEN-1:0] pc, int holds,
                            bit has_result, reg_addr_t rd, logic [XLEN-1:0] value);
        tbl[n_entries] = '{name, word, pc, holds, has_result, rd, value};
        n_entries++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table with hand-worked results
    task automatic build_table();
        n_entries = 0;
        // x1 = -5, x2 = 100
        add_test("addi_neg", make_i(12'hFFB, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM), 0, 0,
                 1, 5'd1, 32'hFFFF_FFFB);
        add_test("addi_pos", make_i(12'h064, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 0, 0,
                 1, 5'd2, 32'h0000_0064);
        add_test("slti", make_i(12'h005, 5'd1, F3_SLT, 5'd3, OPC_OP_IMM), 0, 1,
                 1, 5'd3, 32'h1);
        add_test("sltiu", make_i(12'h005, 5'd1, F3_SLTU, 5'd4, OPC_OP_IMM), 0, 0,
                 1, 5'd4, 32'h0);
        add_test("xori", make_i(12'h0F0, 5'd2, F3_XOR, 5'd5, OPC_OP_IMM), 0, 0,
                 1, 5'd5, 32'h0000_0094);
        add_test("ori", make_i(12'hF00, 5'd2, F3_OR, 5'd6, OPC_OP_IMM), 0, 2,
                 1, 5'd6, 32'hFFFF_FF64);
        add_test("andi", make_i(12'h07F, 5'd1, F3_AND, 5'd7, OPC_OP_IMM), 0, 0,
                 1, 5'd7, 32'h0000_007B);
        add_test("slli", make_i(12'h004, 5'd2, F3_SLL, 5'd8, OPC_OP_IMM), 0, 0,
                 1, 5'd8, 32'h0000_0640);
        add_test("srli", make_i(12'h01C, 5'd1, F3_SR, 5'd9, OPC_OP_IMM), 0, 0,
                 1, 5'd9, 32'h0000_000F);
        add_test("srai", make_i(12'h401, 5'd1, F3_SR, 5'd10, OPC_OP_IMM), 0, 3,
                 1, 5'd10, 32'hFFFF_FFFD);
        add_test("add", make_r(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd11, OPC_OP), 0, 0,
                 1, 5'd11, 32'h0000_005F);
        add_test("sub", make_r(7'h20, 5'd1, 5'd2, F3_ADD_SUB, 5'd12, OPC_OP), 0, 0,
                 1, 5'd12, 32'h0000_0069);
        add_test("slt", make_r(7'h00, 5'd2, 5'd1, F3_SLT, 5'd13, OPC_OP), 0, 0,
                 1, 5'd13, 32'h1);
        add_test("sltu", make_r(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd14, OPC_OP), 0, 0,
                 1, 5'd14, 32'h0);
        add_test("xor", make_r(7'h00, 5'd8, 5'd5, F3_XOR, 5'd15, OPC_OP), 0, 0,
                 1, 5'd15, 32'h0000_06D4);
        add_test("or", make_r(7'h00, 5'd8, 5'd7, F3_OR, 5'd16, OPC_OP), 0, 1,
                 1, 5'd16, 32'h0000_067B);
        add_test("and", make_r(7'h00, 5'd1, 5'd6, F3_AND, 5'd17, OPC_OP), 0, 0,
                 1, 5'd17, 32'hFFFF_FF60);
        add_test("sll", make_r(7'h00, 5'd9, 5'd2, F3_SLL, 5'd18, OPC_OP), 0, 0,
                 1, 5'd18, 32'h0032_0000);
        add_test("srl", make_r(7'h00, 5'd3, 5'd1, F3_SR, 5'd19, OPC_OP), 0, 0,
                 1, 5'd19, 32'h7FFF_FFFD);
        add_test("sra", make_r(7'h20, 5'd3, 5'd1, F3_SR, 5'd20, OPC_OP), 0, 0,
                 1, 5'd20, 32'hFFFF_FFFD);
        // Back-to-back chain on x21, x24, x25
        add_test("lui", make_u(20'h12345, 5'd21, OPC_LUI), 0, 0,
                 1, 5'd21, 32'h1234_5000);
        add_test("dep_addi", make_i(12'h678, 5'd21, F3_ADD_SUB, 5'd24, OPC_OP_IMM), 0, 0,
                 1, 5'd24, 32'h1234_5678);
        add_test("dep_add", make_r(7'h00, 5'd24, 5'd24, F3_ADD_SUB, 5'd25, OPC_OP), 0, 0,
                 1, 5'd25, 32'h2468_ACF0);
        add_test("dep_sub", make_r(7'h20, 5'd24, 5'd25, F3_ADD_SUB, 5'd26, OPC_OP), 0, 0,
                 1, 5'd26, 32'h1234_5678);
        add_test("auipc", make_u(20'h00010, 5'd22, OPC_AUIPC), 32'h0000_0400, 0,
                 1, 5'd22, 32'h0001_0400);
        add_test("auipc_wrap", make_u(20'hFFFFF, 5'd23, OPC_AUIPC), 32'h0000_1000, 1,
                 1, 5'd23, 32'h0000_0000);
        add_test("write_x0", make_i(12'h007, 5'd2, F3_ADD_SUB, 5'd0, OPC_OP_IMM), 0, 0,
                 1, 5'd0, 32'h0000_006B);
        add_test("read_x0", make_r(7'h00, 5'd2, 5'd0, F3_ADD_SUB, 5'd27, OPC_OP), 0, 0,
                 1, 5'd27, 32'h0000_0064);
        add_test("beq", make_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011), 0, 1,
                 0, 5'd0, 32'h0);
        add_test("lw", make_i(12'h000, 5'd1, 3'b010, 5'd28, 7'b0000011), 0, 0,
                 0, 5'd0, 32'h0);
        add_test("after_lw", make_i(12'h001, 5'd27, F3_ADD_SUB, 5'd29, OPC_OP_IMM), 0, 2,
                 1, 5'd29, 32'h0000_0065);
        add_test("x28_unwritten", make_r(7'h00, 5'd0, 5'd28, F3_ADD_SUB, 5'd30, OPC_OP), 0, 0,
                 1, 5'd30, 32'h0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_data(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s data expected %08h actual %08h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_rd(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s rd expected x%0d actual x%0d", name, exp, act);
            rd_errors++;
        end
    endtask

    // Results sampled mid-cycle, matched in program order
    always @(negedge clk) begin
        int idx;
        if (!rst && result_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("Unexpected result on x%0d with data %08h", result_rd, result_data);
                other_errors++;
            end else begin
                idx = pending.pop_front();
                check_rd(tbl[idx].name, tbl[idx].rd, result_rd);
                check_data(tbl[idx].name, tbl[idx].value, result_data);
                results_seen++;
            end
        end
    end

    // Hold gap with random junk on the idle inputs
    task automatic hold_gap(int cycles);
        repeat (cycles) begin
            hold        = 1'b1;
            instr_valid = 1'b0;
            instr_word  = $random(seed);
            instr_pc    = $random(seed);
            @(negedge clk);
        end
    endtask

    task automatic issue_entry(int idx);
        bit taken;
        hold_gap(tbl[idx].holds);
        hold        = 1'b0;
        instr_valid = 1'b1;
        instr_word  = tbl[idx].word;
        instr_pc    = tbl[idx].pc;
        taken       = 1'b0;
        while (!taken) begin
            #(CLK_PERIOD / 4);
            if (decode_advance === 1'b1) begin
                taken = 1'b1;
                if (tbl[idx].has_result)
                    pending.push_back(idx);
            end
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    initial begin
        #((N_TESTS * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: only %0d of %0d results arrived", results_seen, expect_total);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed         = 97081;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr_pc     = '0;
        instr_word   = '0;
        hold         = 1'b0;
        rd_errors    = 0;
        data_errors  = 0;
        other_errors = 0;
        results_seen = 0;
        expect_total = 0;
        build_table();
        for (int i = 0; i < n_entries; i++) begin
            if (tbl[i].has_result)
                expect_total++;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            issue_entry(i);
        end
        instr_valid = 1'b0;
        hold        = 1'b0;

        // Results still in flight drain within a few cycles
        drain = 0;
        while (results_seen != expect_total && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        // Catch stray or duplicated results
        repeat (4) @(negedge clk);
        if (pending.size() != 0) begin
            $display("%0d results never arrived", pending.size());
            other_errors++;
        end

        $display("Errors: rd %0d, data %0d, other %0d", rd_errors, data_errors, other_errors);
        if (rd_errors + data_errors + other_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/rv_issue_pkg.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/reg_result.sv
rtl/issue_core_top.sv
tb/issue_core_properties.sv
tb/issue_core_tb.sv
